/* hdl/issue_pkg.sv */
// Issue stage shared definitions
// Tag and data widths, ALU opcodes and the two views of the operand word
package issue_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int TAG_W  = 4;
	localparam int OP_W   = 3;
	localparam int DATA_W = 16;

	// ============================================================
	// ALU opcodes
	// ============================================================
	localparam logic [OP_W-1:0] OP_ADD = 3'd0;
	localparam logic [OP_W-1:0] OP_SUB = 3'd1;
	localparam logic [OP_W-1:0] OP_AND = 3'd2;
	localparam logic [OP_W-1:0] OP_OR  = 3'd3;
	localparam logic [OP_W-1:0] OP_XOR = 3'd4;
	localparam logic [OP_W-1:0] OP_SLL = 3'd5;
	localparam logic [OP_W-1:0] OP_SRL = 3'd6;
	localparam logic [OP_W-1:0] OP_SLT = 3'd7;

	// The 32-bit operand word reads as two registers or as a register
	// plus a shift amount and a 12-bit immediate
	typedef union packed {
		struct packed {
			logic [DATA_W-1:0] src_a;
			logic [DATA_W-1:0] src_b;
		} reg_form;
		struct packed {
			logic [DATA_W-1:0] src_a;
			logic [3:0]        shamt;
			logic [11:0]       imm;
		} imm_form;
	} operand_word_t;

	// A stored entry holds tag, op, is_imm, wait_valid, wait_tag and the
	// operand word, with the most significant field first
	localparam int UOP_W = TAG_W + OP_W + 1 + 1 + TAG_W + $bits(operand_word_t);

endpackage

/* hdl/free_slot_finder.sv */
// Lowest set bit finder
// Reports the first set position from bit 0 upward and whether any bit is set
module free_slot_finder #(
	parameter int DP = 8
) (
	input  logic [DP-1:0]         in_bits,
	output logic [$clog2(DP)-1:0] index,
	output logic                  found
);

	localparam int IW = $clog2(DP);

	// Scan from the top down so the lowest set position is the last
	// one written and therefore wins
	always_comb begin
		index = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (in_bits[i]) begin
				index = IW'(i);
			end
		end
	end

	assign found = |in_bits;

endmodule

/* hdl/issue_buffer.sv */
// Out-of-order issue buffer
// Parallel slot registers with per-slot valid bits, so any slot may leave
module issue_buffer #(
	parameter int DP = 8,
	parameter int DW = issue_pkg::UOP_W
) (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  push,
	input  logic [DW-1:0]         push_info,
	input  logic                  pop,
	input  logic [$clog2(DP)-1:0] pop_index,
	output logic [DW*DP-1:0]      slot_info,
	output logic [DP-1:0]         slot_valid
);

	logic [$clog2(DP)-1:0] free_index;
	logic [$clog2(DP)-1:0] push_index;
	logic [DP-1:0]         valid_nxt;

	// ============================================================
	// Slot allocation
	// ============================================================

	// The lowest empty slot takes a new entry
	free_slot_finder #(
		.DP(DP)
	) free_finder (
		.in_bits(~slot_valid),
		.index  (free_index),
		.found  ()
	);

	// A push that meets a pop reuses the slot being vacated, so a full
	// buffer can still accept one entry per issued one
	assign push_index = pop ? pop_index : free_index;

	// ============================================================
	// Valid bits
	// ============================================================
	always_comb begin
		valid_nxt = slot_valid;
		if (pop) begin
			valid_nxt[pop_index] = 1'b0;
		end
		// The set follows the clear so a slot both popped and pushed stays valid
		if (push) begin
			valid_nxt[push_index] = 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid <= '0;
		end else begin
			slot_valid <= valid_nxt;
		end
	end

	// ============================================================
	// Slot storage
	// ============================================================
	for (genvar s = 0; s < DP; s++) begin : g_slot
		logic slot_we;

		assign slot_we = push && (push_index == s);

		always_ff @(posedge CLK) begin
			if (slot_we) begin
				slot_info[DW*s +: DW] <= push_info;
			end
		end
	end

endmodule

/* hdl/issue_select.sv */
// Issue select
// Tracks pending tags, marks ready slots and picks the lowest one to issue
module issue_select #(
	parameter int DP = 8
) (
	input  logic                                CLK,
	input  logic                                rst_n,
	input  logic [issue_pkg::UOP_W*DP-1:0]      slot_info,
	input  logic [DP-1:0]                       slot_valid,
	input  logic                                push,
	input  logic [issue_pkg::TAG_W-1:0]         push_tag,
	input  logic                                result_valid,
	input  logic [issue_pkg::TAG_W-1:0]         result_tag,
	output logic                                pop,
	output logic [$clog2(DP)-1:0]               pop_index,
	output logic [issue_pkg::TAG_W-1:0]         issue_tag,
	output logic [issue_pkg::OP_W-1:0]          issue_op,
	output logic                                issue_is_imm,
	output issue_pkg::operand_word_t            issue_operands
);

	localparam int NTAG = 1 << issue_pkg::TAG_W;

	logic [NTAG-1:0] pending;
	logic [NTAG-1:0] done_mask;
	logic [NTAG-1:0] pending_live;
	logic [NTAG-1:0] pending_nxt;
	logic [DP-1:0]   ready;

	logic [issue_pkg::TAG_W-1:0]  s_tag        [DP];
	logic [issue_pkg::OP_W-1:0]   s_op         [DP];
	logic                         s_is_imm     [DP];
	logic                         s_wait_valid [DP];
	logic [issue_pkg::TAG_W-1:0]  s_wait_tag   [DP];
	issue_pkg::operand_word_t     s_operands   [DP];

	// ============================================================
	// Pending-tag scoreboard
	// ============================================================

	// The broadcast clears its tag right away, so a waiting entry can
	// issue in the same cycle its producer's result appears
	assign done_mask    = result_valid ? (NTAG'(1) << result_tag) : '0;
	assign pending_live = pending & ~done_mask;
	assign pending_nxt  = pending_live | (push ? (NTAG'(1) << push_tag) : '0);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			pending <= pending_nxt;
		end
	end

	// ============================================================
	// Per-slot readiness
	// ============================================================
	for (genvar s = 0; s < DP; s++) begin : g_slot
		// Field order matches the packing at the top level
		assign {s_tag[s], s_op[s], s_is_imm[s], s_wait_valid[s], s_wait_tag[s],
			s_operands[s]} = slot_info[issue_pkg::UOP_W*s +: issue_pkg::UOP_W];

		assign ready[s] = slot_valid[s] &&
			(!s_wait_valid[s] || !pending_live[s_wait_tag[s]]);
	end

	// ============================================================
	// Selection
	// ============================================================
	free_slot_finder #(
		.DP(DP)
	) ready_finder (
		.in_bits(ready),
		.index  (pop_index),
		.found  (pop)
	);

	assign issue_tag      = s_tag[pop_index];
	assign issue_op       = s_op[pop_index];
	assign issue_is_imm   = s_is_imm[pop_index];
	assign issue_operands = s_operands[pop_index];

endmodule

/* hdl/alu_exec.sv */
// Single-cycle ALU
// Decodes the operand word by form and registers the tagged result
module alu_exec (
	input  logic                             CLK,
	input  logic                             rst_n,
	input  logic                             issue_valid,
	input  logic [issue_pkg::TAG_W-1:0]      issue_tag,
	input  logic [issue_pkg::OP_W-1:0]       issue_op,
	input  logic                             issue_is_imm,
	input  issue_pkg::operand_word_t         issue_operands,
	output logic                             result_valid,
	output logic [issue_pkg::TAG_W-1:0]      result_tag,
	output logic [issue_pkg::DATA_W-1:0]     result_data
);

	logic                          is_shift;
	logic [issue_pkg::DATA_W-1:0]  op_a;
	logic [issue_pkg::DATA_W-1:0]  op_b;
	logic [3:0]                    sh;
	logic [issue_pkg::DATA_W-1:0]  alu_out;

	// ============================================================
	// Operand decode
	// ============================================================
	assign is_shift = (issue_op == issue_pkg::OP_SLL) || (issue_op == issue_pkg::OP_SRL);

	// src_a sits in the same bits in both forms
	assign op_a = issue_operands.reg_form.src_a;

	always_comb begin
		if (!issue_is_imm) begin
			op_b = issue_operands.reg_form.src_b;
		end else if (is_shift) begin
			op_b = {12'b0, issue_operands.imm_form.shamt};
		end else begin
			op_b = {{4{issue_operands.imm_form.imm[11]}}, issue_operands.imm_form.imm};
		end
	end

	// Register-form shifts use the low bits of src_b, which is also where
	// the zero-extended shamt lands
	assign sh = op_b[3:0];

	// ============================================================
	// Function
	// ============================================================
	always_comb begin
		case (issue_op)
			issue_pkg::OP_ADD: alu_out = op_a + op_b;
			issue_pkg::OP_SUB: alu_out = op_a - op_b;
			issue_pkg::OP_AND: alu_out = op_a & op_b;
			issue_pkg::OP_OR:  alu_out = op_a | op_b;
			issue_pkg::OP_XOR: alu_out = op_a ^ op_b;
			issue_pkg::OP_SLL: alu_out = op_a << sh;
			issue_pkg::OP_SRL: alu_out = op_a >> sh;
			issue_pkg::OP_SLT: alu_out = {15'b0, $signed(op_a) < $signed(op_b)};
			default:           alu_out = '0;
		endcase
	end

	// ============================================================
	// Result register
	// ============================================================
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= issue_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (issue_valid) begin
			result_tag  <= issue_tag;
			result_data <= alu_out;
		end
	end

endmodule

/* hdl/issue_stage.sv */
// Out-of-order issue stage
// Issue buffer, select logic and ALU, with credit return toward the dispatcher
module issue_stage #(
	parameter int DP = 8
) (
	input  logic                             CLK,
	input  logic                             rst_n,
	input  logic                             push,
	input  logic [issue_pkg::TAG_W-1:0]      push_tag,
	input  logic [issue_pkg::OP_W-1:0]       push_op,
	input  logic                             push_is_imm,
	input  logic                             push_wait_valid,
	input  logic [issue_pkg::TAG_W-1:0]      push_wait_tag,
	input  issue_pkg::operand_word_t         push_operands,
	output logic                             credit_return,
	output logic                             result_valid,
	output logic [issue_pkg::TAG_W-1:0]      result_tag,
	output logic [issue_pkg::DATA_W-1:0]     result_data
);

	logic [issue_pkg::UOP_W-1:0]    push_info;
	logic [issue_pkg::UOP_W*DP-1:0] slot_info;
	logic [DP-1:0]                  slot_valid;
	logic                           pop;
	logic [$clog2(DP)-1:0]          pop_index;
	logic [issue_pkg::TAG_W-1:0]    issue_tag;
	logic [issue_pkg::OP_W-1:0]     issue_op;
	logic                           issue_is_imm;
	issue_pkg::operand_word_t       issue_operands;

	// The entry is packed with the most significant field first
	assign push_info = {push_tag, push_op, push_is_imm, push_wait_valid,
		push_wait_tag, push_operands};

	// ============================================================
	// Datapath
	// ============================================================
	issue_buffer #(
		.DP(DP),
		.DW(issue_pkg::UOP_W)
	) buffer0 (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.push      (push),
		.push_info (push_info),
		.pop       (pop),
		.pop_index (pop_index),
		.slot_info (slot_info),
		.slot_valid(slot_valid)
	);

	issue_select #(
		.DP(DP)
	) select0 (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.slot_info     (slot_info),
		.slot_valid    (slot_valid),
		.push          (push),
		.push_tag      (push_tag),
		.result_valid  (result_valid),
		.result_tag    (result_tag),
		.pop           (pop),
		.pop_index     (pop_index),
		.issue_tag     (issue_tag),
		.issue_op      (issue_op),
		.issue_is_imm  (issue_is_imm),
		.issue_operands(issue_operands)
	);

	// Each pop is an issue, so pop doubles as the ALU's valid
	alu_exec alu0 (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.issue_valid   (pop),
		.issue_tag     (issue_tag),
		.issue_op      (issue_op),
		.issue_is_imm  (issue_is_imm),
		.issue_operands(issue_operands),
		.result_valid  (result_valid),
		.result_tag    (result_tag),
		.result_data   (result_data)
	);

	// One credit goes back in the cycle after each issuing edge
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
		end
	end

endmodule

/* bench/issue_stage_tb.sv */
// Testbench for the out-of-order issue stage
// Replays micro-ops from a stimulus file under credit control and checks every result
module issue_stage_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DP      = 8;
	localparam int TIMEOUT = 200;
	localparam int NTAG    = 1 << issue_pkg::TAG_W;

	logic                             CLK;
	logic                             rst_n;
	logic                             push;
	logic [issue_pkg::TAG_W-1:0]      push_tag;
	logic [issue_pkg::OP_W-1:0]       push_op;
	logic                             push_is_imm;
	logic                             push_wait_valid;
	logic [issue_pkg::TAG_W-1:0]      push_wait_tag;
	issue_pkg::operand_word_t         push_operands;
	logic                             credit_return;
	logic                             result_valid;
	logic [issue_pkg::TAG_W-1:0]      result_tag;
	logic [issue_pkg::DATA_W-1:0]     result_data;

	// ============================================================
	// Result table indexed by tag
	// ============================================================
	logic [issue_pkg::DATA_W-1:0] expected   [NTAG];
	bit                           in_flight  [NTAG];
	bit                           done       [NTAG];
	int                           done_cycle [NTAG];
	bit                           has_dep    [NTAG];
	logic [issue_pkg::TAG_W-1:0]  dep_tag    [NTAG];

	int cycle;
	int credits;
	int pushes;
	int results_seen;
	int credits_returned;

	issue_stage #(
		.DP(DP)
	) dut0 (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.push           (push),
		.push_tag       (push_tag),
		.push_op        (push_op),
		.push_is_imm    (push_is_imm),
		.push_wait_valid(push_wait_valid),
		.push_wait_tag  (push_wait_tag),
		.push_operands  (push_operands),
		.credit_return  (credit_return),
		.result_valid   (result_valid),
		.result_tag     (result_tag),
		.result_data    (result_data)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	// ============================================================
	// Error reporting
	// ============================================================
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		stop_run($sformatf("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp));
	endtask

	// ============================================================
	// Monitor called once per falling edge
	// ============================================================
	task automatic check_result();
		logic [issue_pkg::TAG_W-1:0] tag;
		tag = result_tag;
		assert (in_flight[tag]) else
			stop_run($sformatf("Result for tag %0d, which is unknown or already done", tag));
		assert (result_data == expected[tag]) else
			report_mismatch("result_data", result_data, expected[tag]);
		// The producer must have finished in an earlier cycle
		if (has_dep[tag]) begin
			assert (done[dep_tag[tag]] && done_cycle[dep_tag[tag]] < cycle) else
				stop_run($sformatf("Tag %0d finished before the tag %0d it waits on",
					tag, dep_tag[tag]));
		end
		in_flight[tag]  = 1'b0;
		done[tag]       = 1'b1;
		done_cycle[tag] = cycle;
		results_seen++;
	endtask

	task automatic observe_outputs();
		if (credit_return) begin
			credits++;
			credits_returned++;
		end
		if (result_valid) begin
			check_result();
		end
		assert (credits_returned <= pushes) else
			stop_run("More credits came back than micro-ops were pushed");
		assert (credits_returned <= results_seen + 1 && results_seen <= credits_returned + 1)
			else stop_run("Credit returns and results drifted apart");
	endtask

	task automatic tick();
		@(negedge CLK);
		cycle++;
		observe_outputs();
	endtask

	// ============================================================
	// Dispatcher
	// ============================================================
	task automatic wait_for_credit();
		int waited;
		waited = 0;
		while (credits == 0) begin
			tick();
			waited++;
			assert (waited < TIMEOUT) else stop_run("Timed out waiting for a credit");
		end
	endtask

	task automatic push_uop(input logic [3:0] tag, input logic [2:0] op, input logic imm,
		input logic wv, input logic [3:0] wt, input logic [31:0] operands,
		input logic [15:0] exp);
		wait_for_credit();
		assert (!in_flight[tag]) else
			stop_run($sformatf("Stimulus pushes tag %0d while it is still in flight", tag));
		push            = 1'b1;
		push_tag        = tag;
		push_op         = op;
		push_is_imm     = imm;
		push_wait_valid = wv;
		push_wait_tag   = wt;
		push_operands   = operands;
		credits--;
		pushes++;
		expected[tag]  = exp;
		in_flight[tag] = 1'b1;
		done[tag]      = 1'b0;
		has_dep[tag]   = wv;
		dep_tag[tag]   = wt;
		tick();
		push = 1'b0;
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (results_seen < pushes) begin
			tick();
			waited++;
			assert (waited < TIMEOUT) else
				stop_run($sformatf("Timed out with %0d results missing", pushes - results_seen));
		end
		// A few idle cycles catch any stray result
		repeat (4) tick();
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		int          fd;
		int          n;
		string       line;
		logic [7:0]  gap;
		logic [3:0]  tag;
		logic [2:0]  op;
		logic        imm;
		logic        wv;
		logic [3:0]  wt;
		logic [31:0] operands;
		logic [15:0] exp;

		rst_n           = 1'b0;
		push            = 1'b0;
		push_tag        = '0;
		push_op         = '0;
		push_is_imm     = 1'b0;
		push_wait_valid = 1'b0;
		push_wait_tag   = '0;
		push_operands   = '0;
		cycle            = 0;
		credits          = DP;
		pushes           = 0;
		results_seen     = 0;
		credits_returned = 0;
		for (int t = 0; t < NTAG; t++) begin
			in_flight[t] = 1'b0;
			done[t]      = 1'b0;
			has_dep[t]   = 1'b0;
		end

		repeat (5) begin
			@(negedge CLK);
			assert (!result_valid && !credit_return) else
				stop_run("result_valid or credit_return is high during reset");
		end
		rst_n = 1'b1;
		tick();
		assert (!result_valid && !credit_return) else
			stop_run("result_valid or credit_return is high right after reset");

		fd = $fopen("bench/issue_stimulus.txt", "r");
		assert (fd != 0) else stop_run("Cannot open the stimulus file");
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// Blank lines and comment lines carry no micro-op
			if (n > 0 && line.len() > 1 && line.getc(0) != "/") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h",
					gap, tag, op, imm, wv, wt, operands, exp);
				assert (n == 8) else stop_run($sformatf("Malformed stimulus line: %s", line));
				repeat (gap) tick();
				push_uop(tag, op, imm, wv, wt, operands, exp);
			end
		end
		$fclose(fd);

		wait_for_drain();
		assert (credits == DP) else
			stop_run($sformatf("Credit count ends at %0d instead of %0d", credits, DP));

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* bench/issue_stimulus.txt */
// gap tag op is_imm wait_valid wait_tag operands expected, all in hex
// operands: src_a src_b (register form) or src_a shamt imm (immediate form)
// Register form of every opcode, with a short dependency chain
02 0 0 0 0 0 12340111 1345
01 1 1 0 0 0 00050007 fffe
00 2 2 0 0 0 f0f03c3c 3030
00 3 3 0 1 2 12000034 1234
00 4 4 0 1 3 ffff5a5a a5a5
00 5 5 0 1 4 0001fff4 0010
00 6 6 0 0 0 8000000f 0001
00 7 7 0 1 5 ffff0001 0001
// Immediate form of every opcode, negative immediates and shifts by shamt
03 8 0 1 0 0 10000fff 0fff
00 9 1 1 1 8 00100800 0810
02 a 2 1 0 0 abcd70f0 00c0
00 b 3 1 1 a 12000fc0 ffc0
01 c 4 1 0 0 555507ff 52aa
00 d 5 1 0 0 00034fff 0030
00 e 6 1 0 0 f000c123 000f
00 f 7 1 1 e ff000f80 0001
// Sixteen back-to-back pushes with a long chain and fan-out on tag 1
20 0 0 0 0 0 7fff0001 8000
00 1 1 1 1 0 00000001 ffff
00 2 4 0 1 1 11112222 3333
00 3 5 0 1 2 80010001 0002
00 4 2 0 1 1 ffff00ff 00ff
00 5 6 1 1 3 12344000 0123
00 6 7 0 1 1 7fff8000 0000
00 7 3 1 1 5 00000800 f800
00 8 0 1 1 7 ffff0001 0000
00 9 1 0 0 0 80000001 7fff
00 a 6 0 1 9 ffff0010 ffff
00 b 5 1 1 8 00fff000 8000
00 c 7 1 1 a 00050005 0000
00 d 2 1 0 0 12340800 1000
00 e 4 1 1 d 0f0f0fff f0f0
00 f 0 0 1 e 80008000 0000
// Sparse tail after the buffer drains
10 0 7 0 0 0 0002fffe 0000
00 1 1 1 0 0 010097ff f901
02 2 0 1 1 1 fff00010 0000
05 3 6 0 0 0 abcd0004 0abc

/* compile.f */
hdl/issue_pkg.sv
hdl/free_slot_finder.sv
hdl/issue_buffer.sv
hdl/issue_select.sv
hdl/alu_exec.sv
hdl/issue_stage.sv
bench/issue_stage_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = issue_stage_tb
FILELIST = compile.f

PASS_MSG = ALL CHECKS PASSED
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The run passes only if the simulation output holds the pass message
run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
